// ==== tb.f ====
+incdir+logic
logic/memMapPkg.sv
logic/storePkg.sv
logic/memStoreQueue.sv
logic/addrDecoder.sv
logic/bankRam.sv
logic/memSubsystem.sv
dv/memSubsystem_assert.sv
dv/memSubsystem_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module memSubsystem_tb -f tb.f -o memSubsystem_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/memSubsystem_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
   echo "testbench reported a failure, see $LOG"
   exit 1
fi
if [ $status -ne 0 ]; then
   echo "simulator exited with status $status"
   exit 1
fi
echo "run finished cleanly"
exit 0

// ==== dv/memSubsystem_vectors.txt ====
# op addr data exp, hex fields; op W core write, R core read, V generator read, B vgBusy, I idle
# an exp above ff takes the expected byte from the reference model
W 0010 a5 100
R 0010 00 100
W 7000 33 100
R 6000 00 100
W 2040 11 100
W 2058 77 100
B 0000 01 100
W 2040 22 100
W 2041 23 100
V 0040 00 11
B 0000 00 100
V 0040 00 22
V 0041 00 23
R 2041 00 100
B 0000 01 100
W 2050 a0 100
W 2051 a1 100
W 2052 a2 100
W 2053 a3 100
W 2054 a4 100
W 2055 a5 100
W 2056 a6 100
W 2057 a7 100
W 2058 a8 100
B 0000 00 100
R 2058 00 77
V 0057 00 100
R 0800 00 100
R 0a00 00 100
R 0c00 00 100
W 1200 01 100
W 1600 01 100
W 1840 5e 100
R 1840 00 100
R 1870 00 100
R 1000 00 00
W 1400 00 100
I 0000 04 100

// ==== dv/memSubsystem_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "memSystem_settings.svh"

module memSubsystem_tb import memMapPkg::*; ();

   localparam int DRAIN_TIMEOUT = 200;

   logic        clk;
   logic        rst;
   logic        clkEn;
   coreReq_t    coreReq;
   logic [7:0]  dataToCore;
   cabinetIn_t  cabinet;
   periphReq_t  periph;
   periphRsp_t  periphRsp;
   logic        vgBusy;
   logic [12:0] vgAddr;
   logic [7:0]  vgData;
   logic        vgGo;
   logic        vgRst;
   logic        badAccess;
   logic        queueFull;
   logic        queueEmpty;

   // reference model of both RAMs, plus which bytes it has seen written
   logic [7:0]  progModel [1024];
   logic [7:0]  vecModel [8192];
   bit          progKnown [1024];
   bit          vecKnown [8192];
   // vector stores held back while the generator is busy, {addr, data}
   logic [20:0] pending [$];
   int          seed;

   memSubsystem memSubsystem_i (
      .clk(clk), .rst(rst), .clkEn(clkEn), .coreReq(coreReq), .dataToCore(dataToCore),
      .cabinet(cabinet), .periph(periph), .periphRsp(periphRsp), .vgBusy(vgBusy),
      .vgAddr(vgAddr), .vgData(vgData), .vgGo(vgGo), .vgRst(vgRst), .badAccess(badAccess),
      .queueFull(queueFull), .queueEmpty(queueEmpty)
   );

   always #2 clk = ~clk;

   task automatic failRun(input string msg);
      $display("%s", msg);
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic expectByte(input string name, input logic [7:0] got, input logic [7:0] want);
      assert (got === want)
      else failRun($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, want));
   endtask

   task automatic expectWord(input string name, input logic [15:0] got,
                             input logic [15:0] want);
      assert (got === want)
      else failRun($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, want));
   endtask

   task automatic expectBit(input string name, input logic got, input logic want);
      assert (got === want)
      else failRun($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, want));
   endtask

   function automatic bit inVector(input logic [15:0] a);
      return a >= `VECTOR_LO && a <= `VECTOR_HI;
   endfunction

   function automatic bit isPokey(input logic [15:0] a);
      return (a >= `POKEY_LO && a <= `POKEY_HI) || a == `POKEY_SOUND;
   endfunction

   function automatic bit isMath(input logic [15:0] a);
      return a == `MATH_A || a == `MATH_B || a == `MATH_C || (a >= `MATH_LO && a <= `MATH_HI);
   endfunction

   function automatic bit isUnmapped(input logic [15:0] a);
      bit inBank;
      bit special;
      inBank = a <= `PROG_RAM_HI || inVector(a) || (a >= `PROG_ROM_LO && a <= `PROG_ROM_HI) ||
               isPokey(a) || isMath(a);
      special = a == `STATUS_ADDR || a == `OPTION_LO_ADDR || a == `OPTION_HI_ADDR ||
                a == `VG_GO_ADDR || a == `VG_RST_ADDR || a == `WATCHDOG_ADDR;
      return !inBank && !special;
   endfunction

   // returns 0 when the model holds no value for a RAM address
   function automatic bit predictRead(input logic [15:0] a, output logic [7:0] v);
      v = 8'h00;
      if (a <= `PROG_RAM_HI) begin
         v = progModel[a[9:0]];
         return progKnown[a[9:0]];
      end
      if (inVector(a)) begin
         v = vecModel[a[12:0]];
         return vecKnown[a[12:0]];
      end
      if (a >= `PROG_ROM_LO && a <= `PROG_ROM_HI) v = periphRsp.romData;
      else if (isPokey(a)) v = periphRsp.pokeyData;
      else if (isMath(a)) v = periphRsp.mathData;
      else if (a == `STATUS_ADDR) v = {cabinet.clk3k, cabinet.halt, 1'b1, cabinet.selfTest,
                                       3'b111, cabinet.coin};
      else if (a == `OPTION_LO_ADDR) v = cabinet.optionSwitch[7:0];
      else if (a == `OPTION_HI_ADDR) v = cabinet.optionSwitch[15:8];
      return 1'b1;
   endfunction

   task automatic drainQueue();
      int waited;
      logic [20:0] e;
      waited = 0;
      while (!queueEmpty) begin
         waited++;
         if (waited > DRAIN_TIMEOUT) failRun("timed out waiting for the store queue to drain");
         @(negedge clk);
      end
      while (pending.size() > 0) begin
         e = pending.pop_front();
         vecModel[e[20:8]] = e[7:0];
         vecKnown[e[20:8]] = 1'b1;
      end
   endtask

   task automatic coreWrite(input logic [15:0] a, input logic [7:0] d);
      bit vec;
      bit drop;
      vec  = inVector(a);
      drop = vec && vgBusy && pending.size() == `STORE_QUEUE_DEPTH;
      coreReq.addr  = a;
      coreReq.wdata = d;
      coreReq.we    = 1'b1;
      clkEn         = 1'b1;
      if (vec) vgAddr = a[12:0];
      @(negedge clk);
      expectBit("vgGo", vgGo, a == `VG_GO_ADDR);
      expectBit("vgRst", vgRst, a == `VG_RST_ADDR);
      expectWord("periph.addr", periph.addr, a);
      expectByte("periph.wdata", periph.wdata, d);
      expectBit("periph.weRom", periph.weRom, 1'b0);
      expectBit("periph.wePokey", periph.wePokey, isPokey(a));
      expectBit("periph.weMath", periph.weMath, isMath(a));
      expectBit("periph.soundAccess", periph.soundAccess, a == `POKEY_SOUND);
      expectBit("badAccess", badAccess, isUnmapped(a));
      coreReq.we = 1'b0;
      clkEn      = 1'b0;
      if (a <= `PROG_RAM_HI) begin
         progModel[a[9:0]] = d;
         progKnown[a[9:0]] = 1'b1;
      end
      if (vec && vgBusy) begin
         if (!drop) pending.push_back({a[12:0], d});
         expectBit("queueFull", queueFull, pending.size() == `STORE_QUEUE_DEPTH);
         expectBit("queueEmpty", queueEmpty, 1'b0);
         // generator still sees committed contents only
         if (vecKnown[a[12:0]]) expectByte("vgData", vgData, vecModel[a[12:0]]);
      end
      // we low for a cycle so the next write makes a fresh edge
      @(negedge clk);
      if (vec && !vgBusy) begin
         pending.push_back({a[12:0], d});
         drainQueue();
      end
   endtask

   task automatic coreRead(input logic [15:0] a, input logic [8:0] exp);
      logic [7:0] want;
      bit known;
      coreReq.addr = a;
      coreReq.we   = 1'b0;
      clkEn        = 1'b1;
      @(negedge clk);
      expectBit("badAccess", badAccess, isUnmapped(a));
      clkEn = 1'b0;
      @(negedge clk);
      expectBit("badAccess", badAccess, 1'b0);
      known = predictRead(a, want);
      if (exp <= 9'h0ff) begin
         want  = exp[7:0];
         known = 1'b1;
      end
      if (!known) failRun("core read of a RAM address the reference model never wrote");
      expectByte("dataToCore", dataToCore, want);
   endtask

   task automatic vgRead(input logic [12:0] a, input logic [8:0] exp);
      logic [7:0] want;
      vgAddr = a;
      @(negedge clk);
      want = (exp <= 9'h0ff) ? exp[7:0] : vecModel[a];
      if (exp > 9'h0ff && !vecKnown[a]) failRun("generator read of a never written address");
      expectByte("vgData", vgData, want);
   endtask

   task automatic setBusy(input logic level);
      vgBusy = level;
      @(negedge clk);
      if (!level) drainQueue();
   endtask

   initial begin
      int fd;
      int n;
      string line;
      logic [7:0] op;
      logic [15:0] a;
      logic [7:0] d;
      logic [8:0] exp;
      logic [31:0] rnd;
      seed      = 32'h9e82;
      rnd       = $random(seed);
      periphRsp = rnd[23:0];
      rnd       = $random(seed);
      cabinet   = rnd[19:0];
      clk       = 1'b0;
      rst       = 1'b1;
      clkEn     = 1'b0;
      coreReq   = '0;
      vgBusy    = 1'b0;
      vgAddr    = '0;
      repeat (16) @(negedge clk);
      rst = 1'b0;
      expectBit("queueFull", queueFull, 1'b0);
      expectBit("queueEmpty", queueEmpty, 1'b1);
      expectBit("badAccess", badAccess, 1'b0);

      fd = $fopen("dv/memSubsystem_vectors.txt", "r");
      if (fd == 0) failRun("cannot open dv/memSubsystem_vectors.txt");
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() < 2 || line[0] == "#") continue;
         n = $sscanf(line, "%s %h %h %h", op, a, d, exp);
         if (n != 4) failRun($sformatf("malformed vector line: %s", line));
         case (op)
            "W": coreWrite(a, d);
            "R": coreRead(a, exp);
            "V": vgRead(a[12:0], exp);
            "B": setBusy(d[0]);
            "I": repeat (d) @(negedge clk);
            default: failRun($sformatf("unknown opcode in vector line: %s", line));
         endcase
      end
      $fclose(fd);
      $display("Simulation passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== dv/memSubsystem_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module memSubsystem_assert #(
   parameter int DEPTH = 8
) (
   input wire             clk,
   input wire             rst,
   input wire             full,
   input wire             empty,
   input wire [DEPTH-1:0] valid,
   input wire             headValid
);

   // the fill count has to agree with the per-entry valid bits
   flagsMatchValid: assert property (@(posedge clk) disable iff (rst)
      (full == (&valid)) && (empty == !(|valid)))
      else $error("store queue full or empty flag disagrees with its valid bits");

   // a write edge on a full queue must be dropped
   pushWhileFull: assert property (@(posedge clk) disable iff (rst) full && !headValid |=> full)
      else $error("store queue accepted an entry while full");

   validWhileEmpty: assert property (@(posedge clk) disable iff (rst) empty |-> !headValid)
      else $error("headValid is high while the store queue is empty");

endmodule

bind memStoreQueue memSubsystem_assert #(.DEPTH(DEPTH)) queueChecks_i (
   .clk(clk), .rst(rst), .full(full), .empty(empty), .valid(valid), .headValid(headValid)
);

`default_nettype wire

// ==== logic/memSubsystem.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "memSystem_settings.svh"

module memSubsystem import memMapPkg::*, storePkg::*; (
   input  wire         clk,
   input  wire         rst,
   input  wire         clkEn,
   input  coreReq_t    coreReq,
   output logic [7:0]  dataToCore,
   input  cabinetIn_t  cabinet,
   output periphReq_t  periph,
   input  periphRsp_t  periphRsp,
   input  wire         vgBusy,
   input  wire [12:0]  vgAddr,
   output logic [7:0]  vgData,
   output logic        vgGo,
   output logic        vgRst,
   output logic        badAccess,
   output logic        queueFull,
   output logic        queueEmpty
);

   logic        progRamWe;
   logic [9:0]  progRamAddr;
   logic [7:0]  progRamData;
   logic [7:0]  vecRamData;
   logic [12:0] vecRamAddr;
   storeEntry_t vecStore;
   logic        vecWe;
   storeEntry_t head;
   logic        headValid;

   addrDecoder decoder_i (
      .clk(clk), .rst(rst), .clkEn(clkEn), .req(coreReq), .cabinet(cabinet),
      .progRamData(progRamData), .vecRamData(vecRamData), .periphRsp(periphRsp),
      .dataToCore(dataToCore), .progRamWe(progRamWe), .progRamAddr(progRamAddr),
      .vecStore(vecStore), .vecWe(vecWe), .vecRamAddr(vecRamAddr), .periph(periph),
      .vgGo(vgGo), .vgRst(vgRst), .badAccess(badAccess)
   );

   // drains only while the vector generator is idle
   memStoreQueue #(.DEPTH(`STORE_QUEUE_DEPTH)) storeQueue_i (
      .clk(clk), .rst(rst), .storeIn(vecStore), .writeEn(vecWe), .canWrite(!vgBusy),
      .head(head), .headValid(headValid), .full(queueFull), .empty(queueEmpty)
   );

   bankRam #(.WORDS(`PROG_RAM_WORDS)) progRam (
      .clk(clk), .we(progRamWe), .wAddr(progRamAddr), .rAddrA(progRamAddr),
      .rAddrB(progRamAddr), .wData(coreReq.wdata), .rDataA(progRamData), .rDataB()
   );

   // port A serves the core, port B the vector generator
   bankRam #(.WORDS(`VECTOR_RAM_WORDS)) vectorRam (
      .clk(clk), .we(headValid), .wAddr(head.addr[12:0]), .rAddrA(vecRamAddr),
      .rAddrB(vgAddr), .wData(head.data), .rDataA(vecRamData), .rDataB(vgData)
   );

endmodule

`default_nettype wire

// ==== logic/bankRam.sv ====
`timescale 1ns/1ps
`default_nettype none

module bankRam #(
   parameter  int WORDS = 1024,
   localparam int AW    = $clog2(WORDS)
) (
   input  wire          clk,
   input  wire          we,
   input  wire [AW-1:0] wAddr,
   input  wire [AW-1:0] rAddrA,
   input  wire [AW-1:0] rAddrB,
   input  wire [7:0]    wData,
   output logic [7:0]   rDataA,
   output logic [7:0]   rDataB
);

   logic [7:0] mem [WORDS];

   // a read of the address being written returns the old byte
   always_ff @(posedge clk) begin
      if (we) begin
         mem[wAddr] <= wData;
      end
      rDataA <= mem[rAddrA];
      rDataB <= mem[rAddrB];
   end

endmodule

`default_nettype wire

// ==== logic/addrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "memSystem_settings.svh"

module addrDecoder import memMapPkg::*, storePkg::*; (
   input  wire         clk,
   input  wire         rst,
   input  wire         clkEn,
   input  coreReq_t    req,
   input  cabinetIn_t  cabinet,
   input  wire [7:0]   progRamData,
   input  wire [7:0]   vecRamData,
   input  periphRsp_t  periphRsp,
   output logic [7:0]  dataToCore,
   output logic        progRamWe,
   output logic [9:0]  progRamAddr,
   output storeEntry_t vecStore,
   output logic        vecWe,
   output logic [12:0] vecRamAddr,
   output periphReq_t  periph,
   output logic        vgGo,
   output logic        vgRst,
   output logic        badAccess
);

   bankSel_t    bank;
   bankSel_t    bankQ;
   logic [15:0] addrQ;
   logic        knownAddr;

   always_comb begin
      bank = BANK_NONE;
      if (req.addr <= `PROG_RAM_HI) bank = BANK_PROG_RAM;
      else if (req.addr >= `VECTOR_LO && req.addr <= `VECTOR_HI) bank = BANK_VECTOR;
      else if (req.addr >= `PROG_ROM_LO && req.addr <= `PROG_ROM_HI) bank = BANK_PROG_ROM;
      else if (req.addr >= `POKEY_LO && req.addr <= `POKEY_HI) bank = BANK_POKEY;
      else if (req.addr == `POKEY_SOUND) bank = BANK_POKEY;
      else if (req.addr == `MATH_A || req.addr == `MATH_B || req.addr == `MATH_C) bank = BANK_MATH;
      else if (req.addr >= `MATH_LO && req.addr <= `MATH_HI) bank = BANK_MATH;
   end

   // addresses outside the banks that still have a meaning
   assign knownAddr = (req.addr == `STATUS_ADDR) || (req.addr == `OPTION_LO_ADDR) ||
                      (req.addr == `OPTION_HI_ADDR) || (req.addr == `VG_GO_ADDR) ||
                      (req.addr == `VG_RST_ADDR) || (req.addr == `WATCHDOG_ADDR);

   assign vgGo  = req.we && (req.addr == `VG_GO_ADDR);
   assign vgRst = req.we && (req.addr == `VG_RST_ADDR);

   // writes go straight to the core address, reads use the latched one
   assign progRamWe   = req.we && (bank == BANK_PROG_RAM);
   assign progRamAddr = req.we ? req.addr[9:0] : addrQ[9:0];

   assign vecWe         = req.we && (bank == BANK_VECTOR);
   assign vecStore.addr = req.addr;
   assign vecStore.data = req.wdata;
   assign vecRamAddr    = addrQ[12:0];

   always_comb begin
      periph.addr        = req.addr;
      periph.wdata       = req.wdata;
      // ROM is read-only from the core side
      periph.weRom       = 1'b0;
      periph.wePokey     = req.we && (bank == BANK_POKEY);
      periph.weMath      = req.we && (bank == BANK_MATH);
      periph.soundAccess = (req.addr == `POKEY_SOUND);
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         bankQ     <= BANK_NONE;
         badAccess <= 1'b0;
      end else begin
         badAccess <= clkEn && (bank == BANK_NONE) && !knownAddr;
         if (clkEn) bankQ <= bank;
      end
   end

   always_ff @(posedge clk) begin
      if (clkEn) addrQ <= req.addr;
   end

   always_comb begin
      case (bankQ)
         BANK_PROG_RAM: dataToCore = progRamData;
         BANK_VECTOR:   dataToCore = vecRamData;
         BANK_PROG_ROM: dataToCore = periphRsp.romData;
         BANK_POKEY:    dataToCore = periphRsp.pokeyData;
         BANK_MATH:     dataToCore = periphRsp.mathData;
         default: begin
            case (addrQ)
               `STATUS_ADDR: dataToCore = {cabinet.clk3k, cabinet.halt, 1'b1,
                                           cabinet.selfTest, 3'b111, cabinet.coin};
               `OPTION_LO_ADDR: dataToCore = cabinet.optionSwitch[7:0];
               `OPTION_HI_ADDR: dataToCore = cabinet.optionSwitch[15:8];
               default:         dataToCore = 8'h00;
            endcase
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== logic/memStoreQueue.sv ====
`timescale 1ns/1ps
`default_nettype none

module memStoreQueue import storePkg::*; #(
   parameter int DEPTH = 8
) (
   input  wire         clk,
   input  wire         rst,
   input  storeEntry_t storeIn,
   input  wire         writeEn,
   input  wire         canWrite,
   output storeEntry_t head,
   output logic        headValid,
   output logic        full,
   output logic        empty
);

   localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   storeEntry_t      entries [DEPTH];
   logic [DEPTH-1:0] valid;
   logic [IDX_W-1:0] wrIdx;
   logic [IDX_W-1:0] rdIdx;
   logic [CNT_W-1:0] count;
   logic             lastWriteEn;
   logic             push;
   logic             pop;

   function automatic logic [IDX_W-1:0] nextIdx(input logic [IDX_W-1:0] idx);
      return (idx == IDX_W'(DEPTH - 1)) ? '0 : idx + 1'b1;
   endfunction

   assign full  = (count == CNT_W'(DEPTH));
   assign empty = (count == '0);

   // only a rising edge of writeEn stores, held levels are ignored
   assign push = writeEn && !lastWriteEn && !full;

   // the head entry is only offered while the generator leaves the RAM alone
   assign headValid = canWrite && valid[rdIdx];
   assign pop       = headValid;
   assign head      = entries[rdIdx];

   always_ff @(posedge clk) begin
      if (rst) begin
         lastWriteEn <= 1'b0;
         wrIdx       <= '0;
         rdIdx       <= '0;
         count       <= '0;
         valid       <= '0;
      end else begin
         lastWriteEn <= writeEn;
         if (push) begin
            valid[wrIdx] <= 1'b1;
            wrIdx        <= nextIdx(wrIdx);
         end
         if (pop) begin
            valid[rdIdx] <= 1'b0;
            rdIdx        <= nextIdx(rdIdx);
         end
         // push and pop together leave the count alone
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         entries[wrIdx] <= storeIn;
      end
   end

endmodule

`default_nettype wire

// ==== logic/storePkg.sv ====
`default_nettype none

package storePkg;

   // one pending vector RAM write
   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  data;
   } storeEntry_t;

endpackage

`default_nettype wire

// ==== logic/memMapPkg.sv ====
`default_nettype none

package memMapPkg;

   typedef enum logic [2:0] {
      BANK_PROG_RAM,
      BANK_VECTOR,
      BANK_PROG_ROM,
      BANK_POKEY,
      BANK_MATH,
      BANK_NONE
   } bankSel_t;

   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  wdata;
      logic        we;
   } coreReq_t;

   // goes out to the external ROM, POKEY and mathbox
   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  wdata;
      logic        weRom;
      logic        wePokey;
      logic        weMath;
      logic        soundAccess;
   } periphReq_t;

   typedef struct packed {
      logic [7:0] romData;
      logic [7:0] pokeyData;
      logic [7:0] mathData;
   } periphRsp_t;

   typedef struct packed {
      logic        clk3k;
      logic        halt;
      logic        selfTest;
      logic        coin;
      logic [15:0] optionSwitch;
   } cabinetIn_t;

endpackage

`default_nettype wire

// ==== logic/memSystem_settings.svh ====
`ifndef MEM_SYSTEM_SETTINGS_SVH
`define MEM_SYSTEM_SETTINGS_SVH

// store queue and bank sizes
`define STORE_QUEUE_DEPTH 8
`define PROG_RAM_WORDS    1024
`define VECTOR_RAM_WORDS  8192

// region bounds, program RAM starts at address 0
`define PROG_RAM_HI    16'h03FF
`define VECTOR_LO      16'h2000
`define VECTOR_HI      16'h3FFF
`define PROG_ROM_LO    16'h5000
`define PROG_ROM_HI    16'h7FFF
`define POKEY_LO       16'h1820
`define POKEY_HI       16'h182F
`define POKEY_SOUND    16'h1840
`define MATH_A         16'h1800
`define MATH_B         16'h1810
`define MATH_C         16'h1818
`define MATH_LO        16'h1860
`define MATH_HI        16'h187F

// single-address locations outside the banks
`define STATUS_ADDR    16'h0800
`define OPTION_LO_ADDR 16'h0A00
`define OPTION_HI_ADDR 16'h0C00
`define VG_GO_ADDR     16'h1200
`define VG_RST_ADDR    16'h1600
`define WATCHDOG_ADDR  16'h1400

`endif
